/* design/stream_pkg.sv */
/*
 * Shared widths and depths for the LMS receive to FX3 stream path.
 * RTL and testbench files refer to these by scoped name, for example
 * stream_pkg::SAMPLE_W, so the sample, pair and bus widths stay in
 * step across every block of the chain.
 */
package stream_pkg;

   //////////////////////////////////////////////////////////////////////
   // LMS6002D receive side
   //////////////////////////////////////////////////////////////////////

   // One receive sample, I or Q
   localparam int SAMPLE_W = 12;

   // I in the low half, Q in the high half
   localparam int PAIR_W = 2 * SAMPLE_W;

   //////////////////////////////////////////////////////////////////////
   // FX3 GPIF side
   //////////////////////////////////////////////////////////////////////

   // GPIF data bus
   localparam int FX3_DW = 16;

   // Zero bits above the I/Q flag, so pad + flag + sample fills the bus
   localparam int FX3_PAD_W = FX3_DW - SAMPLE_W - 1;

   //////////////////////////////////////////////////////////////////////
   // Buffering
   //////////////////////////////////////////////////////////////////////

   // Stream FIFO address width, 8 words deep
   localparam int FIFO_AW = 3;
   localparam int FIFO_DEPTH = 1 << FIFO_AW;

   // Pairs held with the FX3 stalled: FIFO, one in the packer, one in capture
   localparam int CHAIN_CAPACITY = FIFO_DEPTH + 2;

endpackage

/* design/iq_rx_capture.sv */
/*
 * Receive sample capture for the LMS6002D digital interface.
 * Every cycle carries one 12-bit sample with its I/Q select bit. An I
 * sample is held until the next Q arrives, and the two leave as one
 * 24-bit word on a valid/ready stream. Pairs that find the output
 * register still occupied are dropped and set a sticky overflow flag.
 */
module iq_rx_capture (
   input  logic                          sys_clk_pad_i,
   input  logic                          rst_n_i,
   input  logic [stream_pkg::SAMPLE_W-1:0] lms_rxd_i,
   input  logic                          lms_rxiqsel_i,
   input  logic                          pair_ready_i,
   output logic [stream_pkg::PAIR_W-1:0]   pair_data_o,
   output logic                          pair_valid_o,
   output logic                          rx_overflow_o
);

   // Pending I sample
   logic [stream_pkg::SAMPLE_W-1:0] i_hold;
   logic                            i_pending;

   // Q sample that closes a pair this cycle
   logic q_complete;

   // Output register free to take a new pair on this edge
   logic out_free;

   assign q_complete = lms_rxiqsel_i & i_pending;
   assign out_free   = ~pair_valid_o | pair_ready_i;

   //////////////////////////////////////////////////////////////////////
   // Pairing state
   //////////////////////////////////////////////////////////////////////

   // An I arms the pairing, any Q disarms it whether or not it pairs
   always_ff @(posedge sys_clk_pad_i) begin
      if (!rst_n_i) begin
         i_pending <= 1'b0;
      end else begin
         i_pending <= ~lms_rxiqsel_i;
      end
   end

   // A later I simply overwrites the held one
   always_ff @(posedge sys_clk_pad_i) begin
      if (!lms_rxiqsel_i) begin
         i_hold <= lms_rxd_i;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Output register and overflow
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge sys_clk_pad_i) begin
      if (!rst_n_i) begin
         pair_valid_o  <= 1'b0;
         rx_overflow_o <= 1'b0;
      end else begin
         if (pair_valid_o && pair_ready_i) begin
            pair_valid_o <= 1'b0;
         end
         if (q_complete) begin
            if (out_free) begin
               pair_valid_o <= 1'b1;
            end else begin
               // Sticky until reset
               rx_overflow_o <= 1'b1;
            end
         end
      end
   end

   always_ff @(posedge sys_clk_pad_i) begin
      if (q_complete && out_free) begin
         pair_data_o <= {lms_rxd_i, i_hold};
      end
   end

endmodule

/* design/stream_fifo.sv */
/*
 * Single-clock FIFO with valid/ready streams on both sides.
 * Register array with read and write pointers and an occupancy count.
 * Ready on the write side depends on the count only, so a full FIFO
 * never takes a word even when a read happens on the same edge.
 * Read data is shown directly from the array at the read pointer.
 */
module stream_fifo #(
   parameter int DW = stream_pkg::PAIR_W,
   parameter int AW = stream_pkg::FIFO_AW
) (
   input  logic          sys_clk_pad_i,
   input  logic          rst_n_i,
   input  logic [DW-1:0] s_data_i,
   input  logic          s_valid_i,
   output logic          s_ready_o,
   output logic [DW-1:0] m_data_o,
   output logic          m_valid_o,
   input  logic          m_ready_i
);

   logic [DW-1:0] mem [2**AW];

   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;

   // One bit wider than the pointers so 2**AW entries can be counted
   logic [AW:0] count;

   logic do_write;
   logic do_read;

   // Full exactly when the top count bit is set
   assign s_ready_o = ~count[AW];
   assign m_valid_o = (count != '0);
   assign m_data_o  = mem[rd_ptr];

   assign do_write = s_valid_i & s_ready_o;
   assign do_read  = m_valid_o & m_ready_i;

   //////////////////////////////////////////////////////////////////////
   // Pointers and occupancy
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge sys_clk_pad_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_read) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_write, do_read})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   //////////////////////////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge sys_clk_pad_i) begin
      if (do_write) begin
         mem[wr_ptr] <= s_data_i;
      end
   end

endmodule

/* design/fx3_iq_packer.sv */
/*
 * Splits one I/Q pair word back into two sample beats for the FX3.
 * The I half goes out first with the I/Q flag low, then the Q half with
 * the flag high. A new pair is taken only once the Q beat of the held
 * pair has been accepted downstream.
 */
module fx3_iq_packer (
   input  logic                          sys_clk_pad_i,
   input  logic                          rst_n_i,
   input  logic [stream_pkg::PAIR_W-1:0]   s_data_i,
   input  logic                          s_valid_i,
   output logic                          s_ready_o,
   output logic [stream_pkg::SAMPLE_W-1:0] m_data_o,
   output logic                          m_iqsel_o,
   output logic                          m_valid_o,
   input  logic                          m_ready_i
);

   logic [stream_pkg::PAIR_W-1:0] pair_q;
   logic                          has_pair;

   // Low while the I beat is shown, high for the Q beat
   logic phase;

   assign s_ready_o = ~has_pair;
   assign m_valid_o = has_pair;
   assign m_iqsel_o = phase;
   assign m_data_o  = phase ? pair_q[stream_pkg::PAIR_W-1:stream_pkg::SAMPLE_W]
                            : pair_q[stream_pkg::SAMPLE_W-1:0];

   always_ff @(posedge sys_clk_pad_i) begin
      if (!rst_n_i) begin
         has_pair <= 1'b0;
         phase    <= 1'b0;
      end else begin
         if (s_valid_i && s_ready_o) begin
            has_pair <= 1'b1;
            phase    <= 1'b0;
         end else if (m_valid_o && m_ready_i) begin
            if (phase) begin
               // Q beat gone, pair released
               has_pair <= 1'b0;
               phase    <= 1'b0;
            end else begin
               phase <= 1'b1;
            end
         end
      end
   end

   // Pair payload
   always_ff @(posedge sys_clk_pad_i) begin
      if (s_valid_i && s_ready_o) begin
         pair_q <= s_data_i;
      end
   end

endmodule

/* design/fx3_gpif_writer.sv */
/*
 * FX3 GPIF write side. A beat is accepted while the FX3 flag shows
 * room, and the next cycle drives the active-low write strobe with the
 * bus word: zero pad bits, the I/Q flag and the 12-bit sample.
 */
module fx3_gpif_writer (
   input  logic                          sys_clk_pad_i,
   input  logic                          rst_n_i,
   input  logic [stream_pkg::SAMPLE_W-1:0] s_data_i,
   input  logic                          s_iqsel_i,
   input  logic                          s_valid_i,
   output logic                          s_ready_o,
   input  logic                          fx3_flagb_i,
   output logic                          fx3_slwr_n_o,
   output logic [stream_pkg::FX3_DW-1:0]   fx3_dq_o
);

   logic beat_taken;

   // Flag B high means the FX3 buffer can take a word
   assign s_ready_o  = fx3_flagb_i;
   assign beat_taken = s_valid_i & fx3_flagb_i;

   //////////////////////////////////////////////////////////////////////
   // Strobe and bus word
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge sys_clk_pad_i) begin
      if (!rst_n_i) begin
         fx3_slwr_n_o <= 1'b1;
      end else begin
         fx3_slwr_n_o <= ~beat_taken;
      end
   end

   always_ff @(posedge sys_clk_pad_i) begin
      if (beat_taken) begin
         fx3_dq_o <= {{stream_pkg::FX3_PAD_W{1'b0}}, s_iqsel_i, s_data_i};
      end
   end

endmodule

/* design/stream_top.sv */
/*
 * Receive stream top level: LMS6002D samples to the FX3 GPIF bus.
 * Capture pairs I with Q, the FIFO buffers pairs, the packer splits
 * them into sample beats and the GPIF writer puts them on the bus.
 * Everything runs on the board clock with one synchronous reset.
 */
module stream_top (
   input  logic                          sys_clk_pad_i,
   input  logic                          rst_n_i,
   input  logic [stream_pkg::SAMPLE_W-1:0] lms_rxd_i,
   input  logic                          lms_rxiqsel_i,
   input  logic                          fx3_flagb_i,
   output logic                          fx3_slwr_n_o,
   output logic [stream_pkg::FX3_DW-1:0]   fx3_dq_o,
   output logic                          rx_overflow_o
);

   // Capture to FIFO
   logic [stream_pkg::PAIR_W-1:0] pair_data;
   logic                          pair_valid;
   logic                          pair_ready;

   // FIFO to packer
   logic [stream_pkg::PAIR_W-1:0] fifo_data;
   logic                          fifo_valid;
   logic                          fifo_ready;

   // Packer to GPIF writer
   logic [stream_pkg::SAMPLE_W-1:0] beat_data;
   logic                            beat_iq;
   logic                            beat_valid;
   logic                            beat_ready;

   //////////////////////////////////////////////////////////////////////
   // LMS6002D receive
   //////////////////////////////////////////////////////////////////////

   iq_rx_capture rx_capture0 (
      .sys_clk_pad_i (sys_clk_pad_i),
      .rst_n_i       (rst_n_i),
      .lms_rxd_i     (lms_rxd_i),
      .lms_rxiqsel_i (lms_rxiqsel_i),
      .pair_ready_i  (pair_ready),
      .pair_data_o   (pair_data),
      .pair_valid_o  (pair_valid),
      .rx_overflow_o (rx_overflow_o)
   );

   stream_fifo #(
      .DW (stream_pkg::PAIR_W),
      .AW (stream_pkg::FIFO_AW)
   ) usb_fifo (
      .sys_clk_pad_i (sys_clk_pad_i),
      .rst_n_i       (rst_n_i),
      .s_data_i      (pair_data),
      .s_valid_i     (pair_valid),
      .s_ready_o     (pair_ready),
      .m_data_o      (fifo_data),
      .m_valid_o     (fifo_valid),
      .m_ready_i     (fifo_ready)
   );

   //////////////////////////////////////////////////////////////////////
   // FX3 interface
   //////////////////////////////////////////////////////////////////////

   fx3_iq_packer fx3_iq_packer0 (
      .sys_clk_pad_i (sys_clk_pad_i),
      .rst_n_i       (rst_n_i),
      .s_data_i      (fifo_data),
      .s_valid_i     (fifo_valid),
      .s_ready_o     (fifo_ready),
      .m_data_o      (beat_data),
      .m_iqsel_o     (beat_iq),
      .m_valid_o     (beat_valid),
      .m_ready_i     (beat_ready)
   );

   fx3_gpif_writer fx3_if (
      .sys_clk_pad_i (sys_clk_pad_i),
      .rst_n_i       (rst_n_i),
      .s_data_i      (beat_data),
      .s_iqsel_i     (beat_iq),
      .s_valid_i     (beat_valid),
      .s_ready_o     (beat_ready),
      .fx3_flagb_i   (fx3_flagb_i),
      .fx3_slwr_n_o  (fx3_slwr_n_o),
      .fx3_dq_o      (fx3_dq_o)
   );

endmodule

/* dv/stream_top_sva.sv */
/*
 * Concurrent checks bound into the stream top level. Covers the inner
 * valid/ready streams, the FX3 write strobe against flag B and the
 * sticky receive overflow flag. Ports match the top level signal names.
 */
module stream_top_sva (
   input logic                            sys_clk_pad_i,
   input logic                            rst_n_i,
   input logic [stream_pkg::PAIR_W-1:0]   pair_data,
   input logic                            pair_valid,
   input logic                            pair_ready,
   input logic [stream_pkg::PAIR_W-1:0]   fifo_data,
   input logic                            fifo_valid,
   input logic                            fifo_ready,
   input logic [stream_pkg::SAMPLE_W-1:0] beat_data,
   input logic                            beat_iq,
   input logic                            beat_valid,
   input logic                            beat_ready,
   input logic                            fx3_flagb_i,
   input logic                            fx3_slwr_n_o,
   input logic                            rx_overflow_o
);
   timeunit 1ns;
   timeprecision 1ps;

   // Valid holds with stable data until the beat transfers
   pair_hold_a: assert property (@(posedge sys_clk_pad_i) disable iff (!rst_n_i)
      pair_valid && !pair_ready |=> pair_valid && $stable(pair_data))
      else $error("Capture pair changed or vanished before it was accepted");

   fifo_hold_a: assert property (@(posedge sys_clk_pad_i) disable iff (!rst_n_i)
      fifo_valid && !fifo_ready |=> fifo_valid && $stable(fifo_data))
      else $error("FIFO output changed or vanished before it was read");

   beat_hold_a: assert property (@(posedge sys_clk_pad_i) disable iff (!rst_n_i)
      beat_valid && !beat_ready |=> beat_valid && $stable({beat_iq, beat_data}))
      else $error("Packer beat changed or vanished before it was accepted");

   // A write only follows an edge where the FX3 had room
   strobe_a: assert property (@(posedge sys_clk_pad_i) disable iff (!rst_n_i)
      !fx3_slwr_n_o |-> $past(fx3_flagb_i))
      else $error("FX3 write strobe low without flag B on the previous edge");

   overflow_sticky_a: assert property (@(posedge sys_clk_pad_i) disable iff (!rst_n_i)
      rx_overflow_o |=> rx_overflow_o)
      else $error("Overflow flag cleared without a reset");

endmodule

bind stream_top stream_top_sva sva0 (.*);

/* dv/stream_top_tb.sv */
/*
 * Testbench for the LMS receive to FX3 stream top level.
 * Drives random I/Q samples shortly after each clock edge, runs a model
 * of the pairing rule and compares every FX3 write with the next
 * expected bus word. Back-pressure, overflow and a mid-run reset follow.
 */
module stream_top_tb;
   timeunit 1ns;
   timeprecision 1ps;

   // Stimulus length of each test in cycles or pairs
   localparam int T1_PAIRS = 16;
   localparam int T2_CHUNKS = 5;
   localparam int T2_CHUNK = 40;
   localparam int T3_ROUNDS = 12;
   localparam int T3_CYCLES = T3_ROUNDS * 9 * 5;
   localparam int T4_PAIRS = stream_pkg::CHAIN_CAPACITY + 1;
   localparam int T5_CYCLES = 40;
   localparam int STIM_CYCLES = 2 * T1_PAIRS + T2_CHUNKS * T2_CHUNK + T3_CYCLES
                                + 2 * T4_PAIRS + T5_CYCLES;
   localparam int CYCLE_LIMIT = STIM_CYCLES * 4 + 200;

   logic                            clk;
   logic                            rst_n;
   logic [stream_pkg::SAMPLE_W-1:0] rxd;
   logic                            rxiqsel;
   logic                            flagb;
   logic                            slwr_n;
   logic [stream_pkg::FX3_DW-1:0]   dq;
   logic                            overflow;

   // Reference model state
   logic [stream_pkg::FX3_DW-1:0]   expected_q [$];
   logic                            model_i_pending;
   logic [stream_pkg::SAMPLE_W-1:0] model_i_hold;

   logic  random_flagb;
   string test_name;
   int    value_errors;
   int    other_errors;
   int    cycle_count;

   stream_top DUT (
      .sys_clk_pad_i (clk),
      .rst_n_i       (rst_n),
      .lms_rxd_i     (rxd),
      .lms_rxiqsel_i (rxiqsel),
      .fx3_flagb_i   (flagb),
      .fx3_slwr_n_o  (slwr_n),
      .fx3_dq_o      (dq),
      .rx_overflow_o (overflow)
   );

   always #10 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Reference model
   //////////////////////////////////////////////////////////////////////

   // Zero pad bits with the I/Q flag just above the sample
   function automatic logic [stream_pkg::FX3_DW-1:0] bus_word(
      input logic iq, input logic [stream_pkg::SAMPLE_W-1:0] sample);
      logic [stream_pkg::FX3_DW-1:0] w;
      w = '0;
      w[stream_pkg::SAMPLE_W-1:0] = sample;
      w[stream_pkg::SAMPLE_W] = iq;
      return w;
   endfunction

   function automatic void model_sample(
      input logic iq, input logic [stream_pkg::SAMPLE_W-1:0] sample);
      if (!iq) begin
         model_i_pending = 1'b1;
         model_i_hold = sample;
      end else begin
         // Pair lost when the stalled chain is already full
         if (model_i_pending && (flagb || expected_q.size() < 2 * stream_pkg::CHAIN_CAPACITY)) begin
            expected_q.push_back(bus_word(1'b0, model_i_hold));
            expected_q.push_back(bus_word(1'b1, sample));
         end
         model_i_pending = 1'b0;
      end
   endfunction

   //////////////////////////////////////////////////////////////////////
   // Stimulus tasks
   //////////////////////////////////////////////////////////////////////

   function automatic logic [stream_pkg::SAMPLE_W-1:0] random_sample();
      logic [31:0] rnd;
      rnd = $urandom();
      return rnd[stream_pkg::SAMPLE_W-1:0];
   endfunction

   task automatic drive_sample(input logic iq, input logic [stream_pkg::SAMPLE_W-1:0] sample);
      logic [31:0] rnd;
      @(posedge clk);
      #2;
      if (random_flagb) begin
         rnd = $urandom();
         flagb = rnd[0];
      end
      rxiqsel = iq;
      rxd = sample;
      model_sample(iq, sample);
   endtask

   task automatic send_pair();
      drive_sample(1'b0, random_sample());
      drive_sample(1'b1, random_sample());
   endtask

   // Q samples with no I before them pair with nothing
   task automatic idle_cycles(input int n);
      repeat (n) drive_sample(1'b1, random_sample());
   endtask

   task automatic drain();
      while (expected_q.size() != 0) begin
         idle_cycles(1);
      end
      idle_cycles(8);
   endtask

   task automatic check_overflow(input logic expected);
      if (overflow !== expected) begin
         value_errors++;
         $display("FAILED %s expected overflow %b actual %b", test_name, expected, overflow);
      end
   endtask

   // An I is held through reset, and the first sample after it is a Q
   task automatic apply_reset();
      @(posedge clk);
      #2;
      rst_n = 1'b0;
      rxiqsel = 1'b0;
      rxd = random_sample();
      expected_q.delete();
      model_i_pending = 1'b0;
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;
      rxiqsel = 1'b1;
   endtask

   //////////////////////////////////////////////////////////////////////
   // FX3 write monitor and watchdog
   //////////////////////////////////////////////////////////////////////

   always @(negedge clk) begin : write_monitor
      logic [stream_pkg::FX3_DW-1:0] expected_word;
      if (slwr_n == 1'b0) begin
         if (expected_q.size() == 0) begin
            other_errors++;
            $display("Unexpected FX3 write of %h in test %s with no word expected", dq, test_name);
         end else begin
            expected_word = expected_q.pop_front();
            if (dq !== expected_word) begin
               value_errors++;
               $display("FAILED %s expected %h actual %h", test_name, expected_word, dq);
            end
         end
      end
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles, the run did not finish", cycle_count);
         $display("Errors: value %0d, other %0d", value_errors, other_errors + 1);
         $display("Regression failed");
         $finish;
      end
   end

   initial begin
      logic [31:0] rnd;
      int          n_pairs;
      void'($urandom(32'h83e0));
      clk = 1'b0;
      rst_n = 1'b0;
      rxd = '0;
      rxiqsel = 1'b1;
      flagb = 1'b1;
      random_flagb = 1'b0;
      model_i_pending = 1'b0;
      model_i_hold = '0;
      value_errors = 0;
      other_errors = 0;
      cycle_count = 0;
      test_name = "power_on_reset";
      repeat (5) @(posedge clk);
      #2;
      rst_n = 1'b1;

      test_name = "basic_pairing";
      for (int k = 0; k < T1_PAIRS; k++) send_pair();
      drain();

      test_name = "random_iqsel";
      for (int c = 0; c < T2_CHUNKS; c++) begin
         for (int k = 0; k < T2_CHUNK; k++) begin
            rnd = $urandom();
            drive_sample(rnd[0], random_sample());
         end
         drain();
      end

      // Each round starts from an empty chain and sends at most 9 pairs
      test_name = "random_backpressure";
      for (int r = 0; r < T3_ROUNDS; r++) begin
         random_flagb = 1'b1;
         n_pairs = $urandom_range(1, 9);
         for (int k = 0; k < n_pairs; k++) begin
            send_pair();
            idle_cycles($urandom_range(0, 3));
         end
         random_flagb = 1'b0;
         flagb = 1'b1;
         drain();
         check_overflow(1'b0);
      end

      test_name = "overflow";
      flagb = 1'b0;
      for (int k = 0; k < T4_PAIRS; k++) send_pair();
      idle_cycles(2);
      check_overflow(1'b1);
      flagb = 1'b1;
      drain();

      // Pairs left in the chain are cleared by the reset
      test_name = "mid_run_reset";
      flagb = 1'b0;
      for (int k = 0; k < 3; k++) send_pair();
      apply_reset();
      check_overflow(1'b0);
      flagb = 1'b1;
      drive_sample(1'b1, random_sample());
      idle_cycles(10);
      for (int k = 0; k < 5; k++) begin
         send_pair();
         idle_cycles(1);
      end
      drain();

      if (expected_q.size() != 0) begin
         other_errors++;
         $display("%0d expected FX3 words were never written", expected_q.size());
      end
      $display("Errors: value %0d, other %0d", value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

/* verilog.f */
design/stream_pkg.sv
design/iq_rx_capture.sv
design/stream_fifo.sv
design/fx3_iq_packer.sv
design/fx3_gpif_writer.sv
design/stream_top.sv
dv/stream_top_sva.sv
dv/stream_top_tb.sv

/* Makefile */
# Verilator build and run of the stream top level testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= stream_top_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
